// File: design/bitmanip_consts.svh
`ifndef BITMANIP_CONSTS_SVH
`define BITMANIP_CONSTS_SVH

// ------------------------------
// data path
// ------------------------------

// word width, fixed: rev8 and the clmul product split rely on 32
`define BM_XLEN 32

// bit index taken from rs2 for the single-bit ops
`define BM_IDX_W 5

// bytes per word, orc.b / rev8
`define BM_BYTES 4

// ------------------------------
// carry-less multiplier
// ------------------------------

// iteration counter, msb alone set = 32 steps to go
`define BM_CNT_W 6

`endif

// File: design/bitmanip_op_pkg.sv
package bitmanip_op_pkg;

  // ------------------------------
  // internal operation codes
  // ------------------------------
  typedef enum logic [4:0] {
    OP_NONE,    // unknown encoding, completes with zero
    OP_ANDN,
    OP_ORN,
    OP_XNOR,
    OP_SEXTB,
    OP_SEXTH,
    OP_ZEXTH,
    OP_ORCB,
    OP_REV8,
    OP_SH1ADD,  // one code per shift amount
    OP_SH2ADD,
    OP_SH3ADD,
    OP_BCLR,
    OP_BEXT,
    OP_BINV,
    OP_BSET,
    OP_CLMUL,   // iterative group
    OP_CLMULH,
    OP_CLMULR
  } op_e;

  // ------------------------------
  // instruction field encodings
  // ------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011; // reg-reg
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // unary forms live here

  localparam logic [6:0] F7_NEG   = 7'b0100000; // andn / orn / xnor
  localparam logic [6:0] F7_SHADD = 7'b0010000;
  localparam logic [6:0] F7_BCLR  = 7'b0100100; // bext shares it
  localparam logic [6:0] F7_BINV  = 7'b0110100;
  localparam logic [6:0] F7_BSET  = 7'b0010100;
  localparam logic [6:0] F7_CLMUL = 7'b0000101;
  localparam logic [6:0] F7_ZEXT  = 7'b0000100; // zext.h, rs2 field zero

  localparam logic [2:0] F3_ANDN   = 3'b111;
  localparam logic [2:0] F3_ORN    = 3'b110;
  localparam logic [2:0] F3_XNOR   = 3'b100;
  localparam logic [2:0] F3_SH1ADD = 3'b010;
  localparam logic [2:0] F3_SH2ADD = 3'b100;
  localparam logic [2:0] F3_SH3ADD = 3'b110;
  localparam logic [2:0] F3_BOP    = 3'b001; // bclr / binv / bset
  localparam logic [2:0] F3_BEXT   = 3'b101;
  localparam logic [2:0] F3_CLMUL  = 3'b001;
  localparam logic [2:0] F3_CLMULR = 3'b010;
  localparam logic [2:0] F3_CLMULH = 3'b011;
  localparam logic [2:0] F3_ZEXTH  = 3'b100;
  localparam logic [2:0] F3_UNARY  = 3'b001; // sext.b / sext.h
  localparam logic [2:0] F3_BYTE   = 3'b101; // orc.b / rev8

  localparam logic [11:0] FN12_SEXTB = 12'h604;
  localparam logic [11:0] FN12_SEXTH = 12'h605;
  localparam logic [11:0] FN12_ORCB  = 12'h287;
  localparam logic [11:0] FN12_REV8  = 12'h698; // rv32 form

endpackage

// File: design/bitmanip_ctrl_pkg.sv
package bitmanip_ctrl_pkg;

  // ------------------------------
  // sequencer states
  // ------------------------------
  typedef enum logic [1:0] {
    S_IDLE,        // waiting for start
    S_START_CLMUL, // clmul start pulse out
    S_BUSY_CLMUL   // waiting for busy to fall
  } state_e;

endpackage

// File: design/bitmanip_decode.sv
`include "bitmanip_consts.svh"

module bitmanip_decode (
  input  logic                 clk_i,
  input  logic                 rstn_i,
  input  logic                 start_i,
  input  logic [11:0]          funct12_i,
  input  logic [2:0]           funct3_i,
  input  logic [6:0]           opcode_i,
  input  logic [`BM_XLEN-1:0]  rs1_i,
  input  logic [`BM_XLEN-1:0]  rs2_i,
  output bitmanip_op_pkg::op_e op_o,       // latched on start
  output logic                 is_clmul_o, // live decode, for the sequencer
  output logic [`BM_XLEN-1:0]  rs1_o,
  output logic [`BM_XLEN-1:0]  rs2_o
);

  bitmanip_op_pkg::op_e op_d;   // decode of the current fields
  logic [6:0]           funct7; // upper part of funct12

  assign funct7 = funct12_i[11:5];

  // ------------------------------
  // field decode
  // ------------------------------
  always_comb begin
    op_d = bitmanip_op_pkg::OP_NONE; // anything unmatched
    if (opcode_i == bitmanip_op_pkg::OPC_OP) begin
      case (funct7)
        bitmanip_op_pkg::F7_NEG: begin
          case (funct3_i)
            bitmanip_op_pkg::F3_ANDN: op_d = bitmanip_op_pkg::OP_ANDN;
            bitmanip_op_pkg::F3_ORN:  op_d = bitmanip_op_pkg::OP_ORN;
            bitmanip_op_pkg::F3_XNOR: op_d = bitmanip_op_pkg::OP_XNOR;
            default:                  op_d = bitmanip_op_pkg::OP_NONE;
          endcase
        end
        bitmanip_op_pkg::F7_SHADD: begin
          case (funct3_i)
            bitmanip_op_pkg::F3_SH1ADD: op_d = bitmanip_op_pkg::OP_SH1ADD;
            bitmanip_op_pkg::F3_SH2ADD: op_d = bitmanip_op_pkg::OP_SH2ADD;
            bitmanip_op_pkg::F3_SH3ADD: op_d = bitmanip_op_pkg::OP_SH3ADD;
            default:                    op_d = bitmanip_op_pkg::OP_NONE;
          endcase
        end
        bitmanip_op_pkg::F7_BCLR: begin // bclr and bext split on funct3
          if (funct3_i == bitmanip_op_pkg::F3_BOP) op_d = bitmanip_op_pkg::OP_BCLR;
          if (funct3_i == bitmanip_op_pkg::F3_BEXT) op_d = bitmanip_op_pkg::OP_BEXT;
        end
        bitmanip_op_pkg::F7_BINV: begin
          if (funct3_i == bitmanip_op_pkg::F3_BOP) op_d = bitmanip_op_pkg::OP_BINV;
        end
        bitmanip_op_pkg::F7_BSET: begin
          if (funct3_i == bitmanip_op_pkg::F3_BOP) op_d = bitmanip_op_pkg::OP_BSET;
        end
        bitmanip_op_pkg::F7_CLMUL: begin
          case (funct3_i)
            bitmanip_op_pkg::F3_CLMUL:  op_d = bitmanip_op_pkg::OP_CLMUL;
            bitmanip_op_pkg::F3_CLMULH: op_d = bitmanip_op_pkg::OP_CLMULH;
            bitmanip_op_pkg::F3_CLMULR: op_d = bitmanip_op_pkg::OP_CLMULR;
            default:                    op_d = bitmanip_op_pkg::OP_NONE;
          endcase
        end
        bitmanip_op_pkg::F7_ZEXT: begin // rs2 field must be x0
          if (funct3_i == bitmanip_op_pkg::F3_ZEXTH && funct12_i[4:0] == 5'd0)
            op_d = bitmanip_op_pkg::OP_ZEXTH;
        end
        default: op_d = bitmanip_op_pkg::OP_NONE;
      endcase
    end else if (opcode_i == bitmanip_op_pkg::OPC_OP_IMM) begin
      // unary forms, whole funct12 compared
      if (funct3_i == bitmanip_op_pkg::F3_UNARY) begin
        if (funct12_i == bitmanip_op_pkg::FN12_SEXTB) op_d = bitmanip_op_pkg::OP_SEXTB;
        if (funct12_i == bitmanip_op_pkg::FN12_SEXTH) op_d = bitmanip_op_pkg::OP_SEXTH;
      end else if (funct3_i == bitmanip_op_pkg::F3_BYTE) begin
        if (funct12_i == bitmanip_op_pkg::FN12_ORCB) op_d = bitmanip_op_pkg::OP_ORCB;
        if (funct12_i == bitmanip_op_pkg::FN12_REV8) op_d = bitmanip_op_pkg::OP_REV8;
      end
    end
  end

  assign is_clmul_o = op_d inside {bitmanip_op_pkg::OP_CLMUL, bitmanip_op_pkg::OP_CLMULH,
                                   bitmanip_op_pkg::OP_CLMULR};

  // ------------------------------
  // capture on start
  // ------------------------------
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      op_o <= bitmanip_op_pkg::OP_NONE;
    end else if (start_i) begin
      op_o <= op_d; // held until next start
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rs1_o <= rs1_i;
      rs2_o <= rs2_i;
    end
  end

endmodule

// File: design/bitmanip_sequencer.sv
module bitmanip_sequencer (
  input  logic clk_i,
  input  logic rstn_i,
  input  logic start_i,       // only legal while idle
  input  logic is_clmul_i,    // live decode of the started op
  input  logic busy_i,        // clmul still iterating
  output logic clmul_start_o, // one cycle, the cycle after start
  output logic valid_o        // one cycle, result follows next cycle
);

  bitmanip_ctrl_pkg::state_e state_q;

  // ------------------------------
  // control FSM
  // ------------------------------
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q       <= bitmanip_ctrl_pkg::S_IDLE;
      clmul_start_o <= 1'b0;
      valid_o       <= 1'b0;
    end else begin
      clmul_start_o <= 1'b0; // pulses by default
      valid_o       <= 1'b0;
      case (state_q)
        bitmanip_ctrl_pkg::S_IDLE: begin
          if (start_i) begin
            if (is_clmul_i) begin
              clmul_start_o <= 1'b1;
              state_q       <= bitmanip_ctrl_pkg::S_START_CLMUL;
            end else begin
              valid_o <= 1'b1; // single-cycle path, done right away
            end
          end
        end
        // clmul loads on this edge, busy visible next cycle
        bitmanip_ctrl_pkg::S_START_CLMUL: begin
          state_q <= bitmanip_ctrl_pkg::S_BUSY_CLMUL;
        end
        bitmanip_ctrl_pkg::S_BUSY_CLMUL: begin
          if (!busy_i) begin
            valid_o <= 1'b1;
            state_q <= bitmanip_ctrl_pkg::S_IDLE;
          end
        end
        default: begin
          state_q <= bitmanip_ctrl_pkg::S_IDLE;
        end
      endcase
    end
  end

endmodule

// File: design/bitmanip_logic_unit.sv
`include "bitmanip_consts.svh"

module bitmanip_logic_unit (
  input  bitmanip_op_pkg::op_e op_i,
  input  logic [`BM_XLEN-1:0]  rs1_i,
  input  logic [`BM_XLEN-1:0]  rs2_i,
  output logic [`BM_XLEN-1:0]  alu_res_o
);

  logic [`BM_XLEN-1:0] bit_mask; // one-hot at rs2 index
  logic [`BM_XLEN-1:0] orcb_res;
  logic [`BM_XLEN-1:0] rev8_res;

  assign bit_mask = {{(`BM_XLEN-1){1'b0}}, 1'b1} << rs2_i[`BM_IDX_W-1:0];

  // ------------------------------
  // byte-wise ops
  // ------------------------------
  always_comb begin
    for (int b = 0; b < `BM_BYTES; b++) begin
      orcb_res[8*b +: 8] = {8{|rs1_i[8*b +: 8]}};         // nonzero byte -> ff
      rev8_res[8*b +: 8] = rs1_i[8*(`BM_BYTES-1-b) +: 8]; // byte swap
    end
  end

  // ------------------------------
  // result per op
  // ------------------------------
  always_comb begin
    case (op_i)
      // logic with negated rs2
      bitmanip_op_pkg::OP_ANDN: alu_res_o = rs1_i & ~rs2_i;
      bitmanip_op_pkg::OP_ORN:  alu_res_o = rs1_i | ~rs2_i;
      bitmanip_op_pkg::OP_XNOR: alu_res_o = rs1_i ^ ~rs2_i;
      // extension
      bitmanip_op_pkg::OP_SEXTB: alu_res_o = {{(`BM_XLEN-8){rs1_i[7]}}, rs1_i[7:0]};
      bitmanip_op_pkg::OP_SEXTH: alu_res_o = {{(`BM_XLEN-16){rs1_i[15]}}, rs1_i[15:0]};
      bitmanip_op_pkg::OP_ZEXTH: alu_res_o = {{(`BM_XLEN-16){1'b0}}, rs1_i[15:0]};
      bitmanip_op_pkg::OP_ORCB:  alu_res_o = orcb_res;
      bitmanip_op_pkg::OP_REV8:  alu_res_o = rev8_res;
      // shifted add, carry out dropped
      bitmanip_op_pkg::OP_SH1ADD: alu_res_o = rs2_i + {rs1_i[`BM_XLEN-2:0], 1'b0};
      bitmanip_op_pkg::OP_SH2ADD: alu_res_o = rs2_i + {rs1_i[`BM_XLEN-3:0], 2'b00};
      bitmanip_op_pkg::OP_SH3ADD: alu_res_o = rs2_i + {rs1_i[`BM_XLEN-4:0], 3'b000};
      // single bit
      bitmanip_op_pkg::OP_BCLR: alu_res_o = rs1_i & ~bit_mask;
      bitmanip_op_pkg::OP_BEXT: alu_res_o = {{(`BM_XLEN-1){1'b0}}, |(rs1_i & bit_mask)};
      bitmanip_op_pkg::OP_BINV: alu_res_o = rs1_i ^ bit_mask;
      bitmanip_op_pkg::OP_BSET: alu_res_o = rs1_i | bit_mask;
      default: alu_res_o = '0; // OP_NONE and the clmul group
    endcase
  end

endmodule

// File: design/bitmanip_clmul.sv
`include "bitmanip_consts.svh"

module bitmanip_clmul (
  input  logic                 clk_i,
  input  logic                 rstn_i,
  input  logic                 start_i, // load pulse from sequencer
  input  bitmanip_op_pkg::op_e op_i,
  input  logic [`BM_XLEN-1:0]  rs1_i,
  input  logic [`BM_XLEN-1:0]  rs2_i,
  output logic                 busy_o,
  output logic [`BM_XLEN-1:0]  prod_o
);

  localparam logic [`BM_CNT_W-1:0] ITER_LOAD = {1'b1, {(`BM_CNT_W-1){1'b0}}}; // 32 steps

  logic [`BM_CNT_W-1:0]  cnt_q;
  logic [2*`BM_XLEN-1:0] prod_q;    // upper half accumulates, lower half shifts out
  logic [`BM_XLEN-1:0]   rs2_eff;
  logic [`BM_XLEN-1:0]   upper_nxt;
  logic                  is_rev;    // clmulr works on reversed operands

  function automatic logic [`BM_XLEN-1:0] bit_rev(input logic [`BM_XLEN-1:0] x);
    logic [`BM_XLEN-1:0] r;
    for (int i = 0; i < `BM_XLEN; i++) begin
      r[i] = x[`BM_XLEN-1-i];
    end
    return r;
  endfunction

  assign is_rev    = (op_i == bitmanip_op_pkg::OP_CLMULR);
  assign rs2_eff   = is_rev ? bit_rev(rs2_i) : rs2_i;
  assign upper_nxt = prod_q[2*`BM_XLEN-1:`BM_XLEN] ^ (prod_q[0] ? rs2_eff : '0);
  assign busy_o    = |cnt_q;

  // ------------------------------
  // iteration
  // ------------------------------
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= ITER_LOAD;
    end else if (busy_o) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      prod_q <= {{`BM_XLEN{1'b0}}, (is_rev ? bit_rev(rs1_i) : rs1_i)};
    end else if (busy_o) begin
      prod_q <= {1'b0, upper_nxt, prod_q[`BM_XLEN-1:1]}; // add then shift right
    end
  end

  // pick the half for the op
  always_comb begin
    case (op_i)
      bitmanip_op_pkg::OP_CLMULH: prod_o = prod_q[2*`BM_XLEN-1:`BM_XLEN];
      bitmanip_op_pkg::OP_CLMULR: prod_o = bit_rev(prod_q[`BM_XLEN-1:0]);
      default:                    prod_o = prod_q[`BM_XLEN-1:0];
    endcase
  end

endmodule

// File: design/bitmanip_result.sv
`include "bitmanip_consts.svh"

module bitmanip_result (
  input  logic                 clk_i,
  input  logic                 rstn_i,
  input  logic                 valid_i,
  input  bitmanip_op_pkg::op_e op_i,
  input  logic [`BM_XLEN-1:0]  alu_res_i,
  input  logic [`BM_XLEN-1:0]  prod_i,
  output logic [`BM_XLEN-1:0]  res_o   // nonzero only the cycle after valid
);

  logic                is_clmul;
  logic [`BM_XLEN-1:0] res_sel;

  assign is_clmul = op_i inside {bitmanip_op_pkg::OP_CLMUL, bitmanip_op_pkg::OP_CLMULH,
                                 bitmanip_op_pkg::OP_CLMULR};
  assign res_sel  = is_clmul ? prod_i : alu_res_i;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      res_o <= '0;
    end else begin
      res_o <= valid_i ? res_sel : '0; // zero between results
    end
  end

endmodule

// File: design/bitmanip_top.sv
`include "bitmanip_consts.svh"

module bitmanip_top (
  input  logic                clk_i,
  input  logic                rstn_i,
  input  logic                start_i,
  input  logic [11:0]         funct12_i,
  input  logic [2:0]          funct3_i,
  input  logic [6:0]          opcode_i,
  input  logic [`BM_XLEN-1:0] rs1_i,
  input  logic [`BM_XLEN-1:0] rs2_i,
  output logic [`BM_XLEN-1:0] res_o,
  output logic                valid_o
);

  bitmanip_op_pkg::op_e op;          // latched operation
  logic                 is_clmul;    // live decode
  logic [`BM_XLEN-1:0]  rs1_q;
  logic [`BM_XLEN-1:0]  rs2_q;
  logic                 clmul_start;
  logic                 clmul_busy;
  logic [`BM_XLEN-1:0]  prod;
  logic [`BM_XLEN-1:0]  alu_res;

  // ------------------------------
  // decode and control
  // ------------------------------
  bitmanip_decode bitmanip_decode_i (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .start_i    (start_i),
    .funct12_i  (funct12_i),
    .funct3_i   (funct3_i),
    .opcode_i   (opcode_i),
    .rs1_i      (rs1_i),
    .rs2_i      (rs2_i),
    .op_o       (op),
    .is_clmul_o (is_clmul),
    .rs1_o      (rs1_q),
    .rs2_o      (rs2_q)
  );

  bitmanip_sequencer bitmanip_sequencer_i (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .start_i       (start_i),
    .is_clmul_i    (is_clmul),
    .busy_i        (clmul_busy),
    .clmul_start_o (clmul_start),
    .valid_o       (valid_o)
  );

  // ------------------------------
  // execute and result
  // ------------------------------
  bitmanip_logic_unit bitmanip_logic_unit_i (
    .op_i      (op),
    .rs1_i     (rs1_q),
    .rs2_i     (rs2_q),
    .alu_res_o (alu_res)
  );

  bitmanip_clmul bitmanip_clmul_i (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .start_i (clmul_start),
    .op_i    (op),
    .rs1_i   (rs1_q),
    .rs2_i   (rs2_q),
    .busy_o  (clmul_busy),
    .prod_o  (prod)
  );

  bitmanip_result bitmanip_result_i (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .valid_i   (valid_o),
    .op_i      (op),
    .alu_res_i (alu_res),
    .prod_i    (prod),
    .res_o     (res_o)
  );

endmodule

// File: tb/bitmanip_properties.sv
module bitmanip_properties (
  input logic                      clk_i,
  input logic                      rstn_i,
  input logic                      start_i,
  input bitmanip_ctrl_pkg::state_e state_i,
  input logic                      clmul_start_i,
  input logic                      busy_i,
  input logic                      valid_i
);

  // ------------------------------
  // start / valid protocol
  // ------------------------------
  start_only_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
    start_i |-> state_i == bitmanip_ctrl_pkg::S_IDLE)
    else $error("start raised while an operation was in flight");

  valid_one_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
    valid_i |=> !valid_i)
    else $error("valid held for more than one cycle");

  // clmul unit loads on the edge after the pulse
  clmul_start_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
    clmul_start_i |=> busy_i)
    else $error("clmul start not followed by busy");

  busy_not_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
    busy_i |-> state_i != bitmanip_ctrl_pkg::S_IDLE)
    else $error("clmul busy while sequencer idle");

endmodule

bind bitmanip_sequencer bitmanip_properties bitmanip_properties_i (
  .clk_i         (clk_i),
  .rstn_i        (rstn_i),
  .start_i       (start_i),
  .state_i       (state_q),
  .clmul_start_i (clmul_start_o),
  .busy_i        (busy_i),
  .valid_i       (valid_o)
);

// File: tb/bitmanip_tb.sv
`include "bitmanip_consts.svh"

module bitmanip_tb;

  localparam int N_OPS       = 82; // operations issued by main_flow
  localparam int CYCLE_LIMIT = N_OPS * 40 + 50;

  logic                clk_i;
  logic                rstn_i;
  logic                start_i;
  logic [11:0]         funct12_i;
  logic [2:0]          funct3_i;
  logic [6:0]          opcode_i;
  logic [`BM_XLEN-1:0] rs1_i;
  logic [`BM_XLEN-1:0] rs2_i;
  logic [`BM_XLEN-1:0] res_o;
  logic                valid_o;

  logic [31:0]          seed = 32'h13a8;
  logic [31:0]          exp_res;          // expected word of the op in flight
  logic                 exp_clmul;        // op in flight is iterative
  int                   n_err = 0;
  int                   n_issued = 0;
  int                   n_done = 0;
  int                   cyc = 0;          // posedges since time zero
  int                   start_cyc = 0;
  logic                 summary_done = 1'b0;
  bitmanip_op_pkg::op_e op_list [18];

  bitmanip_top bitmanip_top_i (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .start_i   (start_i),
    .funct12_i (funct12_i),
    .funct3_i  (funct3_i),
    .opcode_i  (opcode_i),
    .rs1_i     (rs1_i),
    .rs2_i     (rs2_i),
    .res_o     (res_o),
    .valid_o   (valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic logic [31:0] ref_result(input bitmanip_op_pkg::op_e op,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [63:0] full; // carry-less product
    logic [31:0] r;
    full = '0;
    r    = '0;
    for (int i = 0; i < 32; i++) begin
      if (b[i]) full = full ^ ({32'h0, a} << i);
    end
    case (op)
      bitmanip_op_pkg::OP_ANDN:   r = a & ~b;
      bitmanip_op_pkg::OP_ORN:    r = a | ~b;
      bitmanip_op_pkg::OP_XNOR:   r = ~(a ^ b);
      bitmanip_op_pkg::OP_SEXTB:  r = {{24{a[7]}}, a[7:0]};
      bitmanip_op_pkg::OP_SEXTH:  r = {{16{a[15]}}, a[15:0]};
      bitmanip_op_pkg::OP_ZEXTH:  r = {16'h0, a[15:0]};
      bitmanip_op_pkg::OP_ORCB: begin
        for (int i = 0; i < 4; i++) r[8*i +: 8] = (a[8*i +: 8] != 8'h00) ? 8'hff : 8'h00;
      end
      bitmanip_op_pkg::OP_REV8:   r = {a[7:0], a[15:8], a[23:16], a[31:24]};
      bitmanip_op_pkg::OP_SH1ADD: r = (a << 1) + b; // carry out lost
      bitmanip_op_pkg::OP_SH2ADD: r = (a << 2) + b;
      bitmanip_op_pkg::OP_SH3ADD: r = (a << 3) + b;
      bitmanip_op_pkg::OP_BCLR:   r = a & ~(32'h1 << b[4:0]);
      bitmanip_op_pkg::OP_BEXT:   r = {31'h0, a[b[4:0]]};
      bitmanip_op_pkg::OP_BINV:   r = a ^ (32'h1 << b[4:0]);
      bitmanip_op_pkg::OP_BSET:   r = a | (32'h1 << b[4:0]);
      bitmanip_op_pkg::OP_CLMUL:  r = full[31:0];
      bitmanip_op_pkg::OP_CLMULH: r = full[63:32];
      bitmanip_op_pkg::OP_CLMULR: r = full[62:31]; // reversed-operand window
      default:                    r = '0;
    endcase
    return r;
  endfunction

  // {funct12, funct3, opcode} for an op, unknown pattern for OP_NONE
  function automatic logic [21:0] encode(input bitmanip_op_pkg::op_e op);
    logic [4:0] rf;
    rf = 5'd2; // rs2 register field, not looked at
    case (op)
      bitmanip_op_pkg::OP_ANDN:   return {bitmanip_op_pkg::F7_NEG, rf, 3'b111, bitmanip_op_pkg::OPC_OP};
      bitmanip_op_pkg::OP_ORN:    return {bitmanip_op_pkg::F7_NEG, rf, 3'b110, bitmanip_op_pkg::OPC_OP};
      bitmanip_op_pkg::OP_XNOR:   return {bitmanip_op_pkg::F7_NEG, rf, 3'b100, bitmanip_op_pkg::OPC_OP};
      bitmanip_op_pkg::OP_SH1ADD: return {bitmanip_op_pkg::F7_SHADD, rf, 3'b010, bitmanip_op_pkg::OPC_OP};
      bitmanip_op_pkg::OP_SH2ADD: return {bitmanip_op_pkg::F7_SHADD, rf, 3'b100, bitmanip_op_pkg::OPC_OP};
      bitmanip_op_pkg::OP_SH3ADD: return {bitmanip_op_pkg::F7_SHADD, rf, 3'b110, bitmanip_op_pkg::OPC_OP};
      bitmanip_op_pkg::OP_BCLR:   return {bitmanip_op_pkg::F7_BCLR, rf, 3'b001, bitmanip_op_pkg::OPC_OP};
      bitmanip_op_pkg::OP_BEXT:   return {bitmanip_op_pkg::F7_BCLR, rf, 3'b101, bitmanip_op_pkg::OPC_OP};
      bitmanip_op_pkg::OP_BINV:   return {bitmanip_op_pkg::F7_BINV, rf, 3'b001, bitmanip_op_pkg::OPC_OP};
      bitmanip_op_pkg::OP_BSET:   return {bitmanip_op_pkg::F7_BSET, rf, 3'b001, bitmanip_op_pkg::OPC_OP};
      bitmanip_op_pkg::OP_CLMUL:  return {bitmanip_op_pkg::F7_CLMUL, rf, 3'b001, bitmanip_op_pkg::OPC_OP};
      bitmanip_op_pkg::OP_CLMULR: return {bitmanip_op_pkg::F7_CLMUL, rf, 3'b010, bitmanip_op_pkg::OPC_OP};
      bitmanip_op_pkg::OP_CLMULH: return {bitmanip_op_pkg::F7_CLMUL, rf, 3'b011, bitmanip_op_pkg::OPC_OP};
      bitmanip_op_pkg::OP_ZEXTH:  return {bitmanip_op_pkg::F7_ZEXT, 5'd0, 3'b100, bitmanip_op_pkg::OPC_OP};
      bitmanip_op_pkg::OP_SEXTB:  return {bitmanip_op_pkg::FN12_SEXTB, 3'b001, bitmanip_op_pkg::OPC_OP_IMM};
      bitmanip_op_pkg::OP_SEXTH:  return {bitmanip_op_pkg::FN12_SEXTH, 3'b001, bitmanip_op_pkg::OPC_OP_IMM};
      bitmanip_op_pkg::OP_ORCB:   return {bitmanip_op_pkg::FN12_ORCB, 3'b101, bitmanip_op_pkg::OPC_OP_IMM};
      bitmanip_op_pkg::OP_REV8:   return {bitmanip_op_pkg::FN12_REV8, 3'b101, bitmanip_op_pkg::OPC_OP_IMM};
      default:                    return {7'h7f, 5'd0, 3'b000, bitmanip_op_pkg::OPC_OP};
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      n_err++;
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
    end
  endtask

  // one start pulse, then wait until the compare process took the result
  task automatic run_op(input bitmanip_op_pkg::op_e op, input logic [31:0] a,
                        input logic [31:0] b);
    @(posedge clk_i);
    exp_res   = ref_result(op, a, b);
    exp_clmul = op inside {bitmanip_op_pkg::OP_CLMUL, bitmanip_op_pkg::OP_CLMULH,
                           bitmanip_op_pkg::OP_CLMULR};
    {funct12_i, funct3_i, opcode_i} <= encode(op);
    rs1_i   <= a;
    rs2_i   <= b;
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    n_issued++;
    wait (n_done == n_issued);
  endtask

  // ------------------------------
  // compare process
  // ------------------------------
  initial begin : compare_results
    int lat;
    forever begin
      @(negedge clk_i);
      if (start_i) start_cyc = cyc;
      if (valid_o) begin
        lat = cyc - start_cyc;
        if (!exp_clmul) begin
          check_value("valid_o latency", 32'd1, lat);
        end else if (lat <= 1) begin
          n_err++;
          $display("Error at %0t: carry-less result came as early as a single-cycle one", $time);
        end
        @(negedge clk_i); // res_o lives one cycle after valid_o
        check_value("res_o", exp_res, res_o);
        n_done++;
      end else begin
        check_value("res_o", 32'h0, res_o); // zero outside result cycles
      end
    end
  end

  initial begin : watchdog
    while (cyc < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cyc++;
    end
    $display("Error at %0t: run did not finish within %0d cycles", $time, CYCLE_LIMIT);
    $display("results checked %0d, errors %0d", n_done, n_err + 1);
    summary_done = 1'b1;
    $display("ERRORS FOUND");
    $finish;
  end

  // run stopped before the summary, e.g. by a failed assertion
  final begin
    if (!summary_done) $display("ERRORS FOUND");
  end

  initial begin : main_flow
    logic [31:0] r;
    int          sel;
    op_list = '{bitmanip_op_pkg::OP_ANDN, bitmanip_op_pkg::OP_ORN, bitmanip_op_pkg::OP_XNOR,
                bitmanip_op_pkg::OP_SEXTB, bitmanip_op_pkg::OP_SEXTH, bitmanip_op_pkg::OP_ZEXTH,
                bitmanip_op_pkg::OP_ORCB, bitmanip_op_pkg::OP_REV8, bitmanip_op_pkg::OP_SH1ADD,
                bitmanip_op_pkg::OP_SH2ADD, bitmanip_op_pkg::OP_SH3ADD, bitmanip_op_pkg::OP_BCLR,
                bitmanip_op_pkg::OP_BEXT, bitmanip_op_pkg::OP_BINV, bitmanip_op_pkg::OP_BSET,
                bitmanip_op_pkg::OP_CLMUL, bitmanip_op_pkg::OP_CLMULH, bitmanip_op_pkg::OP_CLMULR};
    rstn_i    = 1'b0;
    start_i   = 1'b0;
    funct12_i = '0;
    funct3_i  = '0;
    opcode_i  = '0;
    rs1_i     = '0;
    rs2_i     = '0;
    repeat (2) @(posedge clk_i);
    rstn_i <= 1'b1;
    repeat (4) begin // quiet after reset
      @(negedge clk_i);
      check_value("valid_o", 32'h0, {31'h0, valid_o});
    end
    for (int k = 0; k < 8; k++) begin // logic, extension, byte ops
      repeat (4) run_op(op_list[k], next_rand(), next_rand());
    end
    for (int k = 8; k < 11; k++) begin // shifted add
      run_op(op_list[k], 32'hffff_ffff, 32'hffff_fff0); // sum wraps
      run_op(op_list[k], 32'h8000_0001, next_rand() | 32'h8000_0000);
      run_op(op_list[k], next_rand(), next_rand());
    end
    for (int k = 11; k < 15; k++) begin // single bit, index 0 and 31
      r = next_rand();
      run_op(op_list[k], next_rand(), {r[31:5], 5'd0});
      run_op(op_list[k], next_rand(), {r[31:5], 5'd31});
      repeat (2) run_op(op_list[k], next_rand(), next_rand());
    end
    for (int k = 15; k < 18; k++) begin // carry-less
      run_op(op_list[k], 32'hffff_ffff, 32'hffff_ffff);
      run_op(op_list[k], 32'h8000_0000, 32'h8000_0000);
      repeat (2) run_op(op_list[k], next_rand(), next_rand());
    end
    run_op(bitmanip_op_pkg::OP_NONE, next_rand(), next_rand());
    repeat (12) begin // back to back mix
      sel = int'(next_rand() % 32'd18);
      run_op(op_list[sel], next_rand(), next_rand());
    end
    repeat (3) @(posedge clk_i);
    $display("results checked %0d, errors %0d", n_done, n_err);
    summary_done = 1'b1;
    if (n_err == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+design
design/bitmanip_op_pkg.sv
design/bitmanip_ctrl_pkg.sv
design/bitmanip_decode.sv
design/bitmanip_sequencer.sv
design/bitmanip_logic_unit.sv
design/bitmanip_clmul.sv
design/bitmanip_result.sv
design/bitmanip_top.sv
tb/bitmanip_properties.sv
tb/bitmanip_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module bitmanip_tb -f tb.f -o bitmanip_sim \
  && ./obj_dir/bitmanip_sim > sim.log 2>&1
status=$?
cat sim.log 2>/dev/null
[ "$status" -eq 0 ] && ! grep -q "ERRORS FOUND" sim.log && echo "simulation passed" && exit 0
echo "simulation failed" || true
exit 1
